// File: bus_requester.sv
// Bus requester
// Runs one bus cycle per command, drives stall and returns read data
`timescale 1ns/10ps
`default_nettype none

module bus_requester (
    input  logic                  spi_cs_ni,      // Design clock
    input  logic                  spi_sck_i,      // Async reset, active high
    input  logic                  frame_start_i,
    input  logic                  frame_end_i,
    cmd_if.sink                   cmd,
    wb_if.master                  bus,
    output logic                  tx_load_o,      // Read data for the shifter
    output spi_bridge_pkg::data_t tx_byte_o,
    output logic                  stall_o         // MCU must wait while high
);

    spi_bridge_pkg::req_state_e state;
    logic                       start;  // Command accepted this cycle

    assign start = (state == spi_bridge_pkg::REQ_RECEIVING) && cmd.valid && !frame_end_i;

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            state     <= spi_bridge_pkg::REQ_IDLE;
            bus.stb   <= 1'b0;
            tx_load_o <= 1'b0;
        end else begin
            bus.stb   <= start;
            tx_load_o <= 1'b0;
            unique case (state)
                spi_bridge_pkg::REQ_IDLE: begin
                    if (frame_start_i) begin
                        state <= spi_bridge_pkg::REQ_RECEIVING;
                    end
                end
                spi_bridge_pkg::REQ_RECEIVING: begin
                    if (frame_end_i) begin
                        state <= spi_bridge_pkg::REQ_IDLE;  // Frame ended early
                    end else if (start) begin
                        state <= spi_bridge_pkg::REQ_BUSY;
                    end
                end
                spi_bridge_pkg::REQ_BUSY: begin
                    if (bus.ack) begin
                        state     <= spi_bridge_pkg::REQ_IDLE;
                        tx_load_o <= ~bus.we;  // Only reads return data
                    end else if (frame_end_i) begin
                        state <= spi_bridge_pkg::REQ_IDLE;
                    end
                end
                default: begin
                    state <= spi_bridge_pkg::REQ_IDLE;
                end
            endcase
        end
    end

    // Cycle payload, captured once per command
    always_ff @(posedge spi_cs_ni) begin
        if (start) begin
            bus.we    <= cmd.we;
            bus.adr   <= cmd.addr;
            bus.dat_w <= cmd.wdata;
        end
        if (state == spi_bridge_pkg::REQ_BUSY && bus.ack && !bus.we) begin
            tx_byte_o <= bus.dat_r;
        end
    end

    assign bus.cyc = (state == spi_bridge_pkg::REQ_BUSY);
    assign stall_o = (state != spi_bridge_pkg::REQ_IDLE);  // Frame open or cycle running

endmodule

`default_nettype wire

// File: cmd_decoder.sv
// Command decoder
// Parses command, data and address bytes, issues one command per frame
`timescale 1ns/10ps
`default_nettype none

module cmd_decoder (
    input  logic                  spi_cs_ni,      // Design clock
    input  logic                  spi_sck_i,      // Async reset, active high
    input  spi_bridge_pkg::data_t rx_byte_i,
    input  logic                  rx_strobe_i,
    input  logic                  frame_start_i,
    cmd_if.source                 cmd
);

    spi_bridge_pkg::dec_state_e state;
    logic                       set_addr;  // Address bytes follow

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            state     <= spi_bridge_pkg::DEC_CMD;
            set_addr  <= 1'b0;
            cmd.valid <= 1'b0;
            cmd.we    <= 1'b0;
            cmd.addr  <= '0;
        end else begin
            cmd.valid <= 1'b0;  // Pulse only
            if (frame_start_i) begin
                state <= spi_bridge_pkg::DEC_CMD;
            end else if (rx_strobe_i) begin
                unique case (state)
                    spi_bridge_pkg::DEC_CMD: begin
                        cmd.we   <= rx_byte_i[spi_bridge_pkg::CMD_WRITE_BIT];
                        set_addr <= rx_byte_i[spi_bridge_pkg::CMD_SETADDR_BIT];
                        if (rx_byte_i[spi_bridge_pkg::CMD_SETADDR_BIT]) begin
                            // A16 comes with the command byte
                            cmd.addr[spi_bridge_pkg::ADDR_WIDTH-1] <=
                                rx_byte_i[spi_bridge_pkg::CMD_A16_BIT];
                        end else begin
                            cmd.addr <= cmd.addr + 1'b1;  // Wraps at 2^17
                        end
                        if (rx_byte_i[spi_bridge_pkg::CMD_WRITE_BIT]) begin
                            state <= spi_bridge_pkg::DEC_DATA;
                        end else if (rx_byte_i[spi_bridge_pkg::CMD_SETADDR_BIT]) begin
                            state <= spi_bridge_pkg::DEC_ADDR_HI;
                        end else begin
                            state     <= spi_bridge_pkg::DEC_DONE;  // Read, next address
                            cmd.valid <= 1'b1;
                        end
                    end
                    spi_bridge_pkg::DEC_DATA: begin
                        if (set_addr) begin
                            state <= spi_bridge_pkg::DEC_ADDR_HI;
                        end else begin
                            state     <= spi_bridge_pkg::DEC_DONE;
                            cmd.valid <= 1'b1;
                        end
                    end
                    spi_bridge_pkg::DEC_ADDR_HI: begin
                        cmd.addr[2*spi_bridge_pkg::DATA_WIDTH-1:spi_bridge_pkg::DATA_WIDTH] <=
                            rx_byte_i;
                        state <= spi_bridge_pkg::DEC_ADDR_LO;
                    end
                    spi_bridge_pkg::DEC_ADDR_LO: begin
                        cmd.addr[spi_bridge_pkg::DATA_WIDTH-1:0] <= rx_byte_i;
                        state     <= spi_bridge_pkg::DEC_DONE;
                        cmd.valid <= 1'b1;
                    end
                    spi_bridge_pkg::DEC_DONE: begin
                        state <= spi_bridge_pkg::DEC_DONE;  // Extra bytes ignored
                    end
                    default: begin
                        state <= spi_bridge_pkg::DEC_CMD;
                    end
                endcase
            end
        end
    end

    // Write data byte
    always_ff @(posedge spi_cs_ni) begin
        if (rx_strobe_i && state == spi_bridge_pkg::DEC_DATA) begin
            cmd.wdata <= rx_byte_i;
        end
    end

endmodule

`default_nettype wire

// File: cmd_if.sv
// Decoded command from the command decoder to the bus requester
// Fields hold until the command byte of the next frame
`timescale 1ns/10ps
`default_nettype none

interface cmd_if;

    logic                  valid;  // One-cycle pulse per frame
    logic                  we;     // 1 = write
    spi_bridge_pkg::addr_t addr;   // Target address
    spi_bridge_pkg::data_t wdata;  // Write data

    // Decoder side
    modport source (
        output valid,
        output we,
        output addr,
        output wdata
    );

    // Requester side
    modport sink (
        input valid,
        input we,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

// File: sim.f
spi_bridge_pkg.sv
cmd_if.sv
wb_if.sv
spi_shifter.sv
cmd_decoder.sv
bus_requester.sv
target_ram.sv
spi_bridge_top.sv
tb_spi_bridge.sv

// File: spi_bridge_pkg.sv
// SPI to memory bridge shared definitions
// Widths, command bit positions, RAM latency and FSM state types
`default_nettype none

package spi_bridge_pkg;

    localparam int DATA_WIDTH      = 8;    // SPI byte and bus word
    localparam int ADDR_WIDTH      = 17;   // Bus address, A16..A0
    localparam int CMD_WRITE_BIT   = 7;    // 1 = write, 0 = read
    localparam int CMD_SETADDR_BIT = 6;    // 1 = set address, 0 = increment
    localparam int CMD_A16_BIT     = 0;    // Carries A16 on set-address
    localparam int RAM_LATENCY     = 2;    // Cycles from stb to ack
    localparam int RAM_DEPTH       = 1 << ADDR_WIDTH;

    // Counter widths
    localparam int BIT_CNT_WIDTH = $clog2(DATA_WIDTH);
    localparam int LAT_CNT_WIDTH = $clog2(RAM_LATENCY + 1);

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [BIT_CNT_WIDTH-1:0] bit_cnt_t;
    typedef logic [LAT_CNT_WIDTH-1:0] lat_cnt_t;

    localparam bit_cnt_t LAST_BIT      = bit_cnt_t'(DATA_WIDTH - 1);  // Last bit of a byte
    localparam lat_cnt_t LAT_CNT_START = lat_cnt_t'(RAM_LATENCY);
    localparam lat_cnt_t LAT_CNT_LAST  = lat_cnt_t'(1);              // Ack count value

    // Command decoder states
    typedef enum logic [2:0] {
        DEC_CMD,        // Waiting for command byte
        DEC_DATA,       // Waiting for write data
        DEC_ADDR_HI,    // Waiting for A15..A8
        DEC_ADDR_LO,    // Waiting for A7..A0
        DEC_DONE        // Command issued, rest of frame ignored
    } dec_state_e;

    // Bus requester states
    typedef enum logic [1:0] {
        REQ_IDLE,       // No frame open
        REQ_RECEIVING,  // Frame open, command not complete yet
        REQ_BUSY        // Bus cycle running
    } req_state_e;

endpackage

`default_nettype wire

// File: spi_bridge_top.sv
// SPI to memory bridge top level
// MCU SPI pins in, shifter, decoder and requester to the built-in RAM
`timescale 1ns/10ps
`default_nettype none

module spi_bridge_top (
    input  logic spi_cs_ni,   // Design clock
    input  logic spi_sck_i,   // Async reset, active high
    input  logic mcu_cs_ni,
    input  logic mcu_sck_i,
    input  logic mcu_sd_i,
    output logic mcu_sd_o,
    output logic stall_o      // MCU flow control
);

    spi_bridge_pkg::data_t rx_byte;
    spi_bridge_pkg::data_t tx_byte;
    logic                  rx_strobe;
    logic                  frame_start;
    logic                  frame_end;
    logic                  tx_load;

    cmd_if cmd_bus ();
    wb_if  wb ();

    spi_shifter u_shifter (
        .spi_cs_ni     (spi_cs_ni),
        .spi_sck_i     (spi_sck_i),
        .mcu_cs_ni     (mcu_cs_ni),
        .mcu_sck_i     (mcu_sck_i),
        .mcu_sd_i      (mcu_sd_i),
        .mcu_sd_o      (mcu_sd_o),
        .tx_load_i     (tx_load),
        .tx_byte_i     (tx_byte),
        .rx_byte_o     (rx_byte),
        .rx_strobe_o   (rx_strobe),
        .frame_start_o (frame_start),
        .frame_end_o   (frame_end)
    );

    cmd_decoder u_decoder (
        .spi_cs_ni     (spi_cs_ni),
        .spi_sck_i     (spi_sck_i),
        .rx_byte_i     (rx_byte),
        .rx_strobe_i   (rx_strobe),
        .frame_start_i (frame_start),
        .cmd           (cmd_bus.source)
    );

    bus_requester u_requester (
        .spi_cs_ni     (spi_cs_ni),
        .spi_sck_i     (spi_sck_i),
        .frame_start_i (frame_start),
        .frame_end_i   (frame_end),
        .cmd           (cmd_bus.sink),
        .bus           (wb.master),
        .tx_load_o     (tx_load),
        .tx_byte_o     (tx_byte),
        .stall_o       (stall_o)
    );

    target_ram u_ram (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .bus       (wb.slave)
    );

endmodule

`default_nettype wire

// File: spi_shifter.sv
// SPI mode 0 shifter, MCU pins oversampled in the design clock
// Shifts bytes in on rising SCK and out on falling SCK, MSB first
`timescale 1ns/10ps
`default_nettype none

module spi_shifter (
    input  logic                  spi_cs_ni,      // Design clock
    input  logic                  spi_sck_i,      // Async reset, active high
    input  logic                  mcu_cs_ni,      // MCU chip select, active low
    input  logic                  mcu_sck_i,      // MCU serial clock
    input  logic                  mcu_sd_i,       // MCU to bridge data
    output logic                  mcu_sd_o,       // Bridge to MCU data
    input  logic                  tx_load_i,      // New read data available
    input  spi_bridge_pkg::data_t tx_byte_i,
    output spi_bridge_pkg::data_t rx_byte_o,
    output logic                  rx_strobe_o,    // One pulse per received byte
    output logic                  frame_start_o,
    output logic                  frame_end_o
);

    logic [1:0] cs_sync;   // Two-flop synchronizers
    logic [1:0] sck_sync;
    logic [1:0] sd_sync;
    logic       cs_q;      // Previous synchronized values
    logic       sck_q;
    logic       sck_rise;
    logic       sck_fall;
    logic       cs_fall;
    logic       cs_rise;
    logic       selected;

    spi_bridge_pkg::bit_cnt_t bit_cnt;                              // Bits of current byte
    logic [spi_bridge_pkg::DATA_WIDTH-2:0] rx_shift;               // Bits received so far
    spi_bridge_pkg::data_t    tx_shift;
    spi_bridge_pkg::data_t    tx_hold;                             // Last read data

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            cs_sync  <= 2'b11;  // Deselected after reset
            sck_sync <= 2'b00;
            sd_sync  <= 2'b00;
            cs_q     <= 1'b1;
            sck_q    <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[0], mcu_cs_ni};
            sck_sync <= {sck_sync[0], mcu_sck_i};
            sd_sync  <= {sd_sync[0], mcu_sd_i};
            cs_q     <= cs_sync[1];
            sck_q    <= sck_sync[1];
        end
    end

    assign selected = ~cs_sync[1];
    assign sck_rise = sck_sync[1] & ~sck_q;
    assign sck_fall = ~sck_sync[1] & sck_q;
    assign cs_fall  = cs_q & ~cs_sync[1];
    assign cs_rise  = ~cs_q & cs_sync[1];

    // Bit counter, strobe and frame pulses
    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bit_cnt       <= '0;
            rx_strobe_o   <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
        end else begin
            rx_strobe_o   <= 1'b0;
            frame_start_o <= cs_fall;
            frame_end_o   <= cs_rise;
            if (!selected) begin
                bit_cnt <= '0;  // Realign on every frame
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == spi_bridge_pkg::LAST_BIT) begin
                    rx_strobe_o <= 1'b1;
                end
            end
        end
    end

    // Receive data path
    always_ff @(posedge spi_cs_ni) begin
        if (selected && sck_rise) begin
            rx_shift <= {rx_shift[spi_bridge_pkg::DATA_WIDTH-3:0], sd_sync[1]};
            if (bit_cnt == spi_bridge_pkg::LAST_BIT) begin
                rx_byte_o <= {rx_shift, sd_sync[1]};  // Full byte incl. last bit
            end
        end
    end

    // Transmit side, first byte of each frame returns tx_hold
    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            tx_hold  <= '0;
            tx_shift <= '0;
        end else begin
            if (tx_load_i) begin
                tx_hold <= tx_byte_i;
            end
            if (cs_fall) begin
                tx_shift <= tx_load_i ? tx_byte_i : tx_hold;  // Bypass a same-cycle load
            end else if (selected && sck_fall) begin
                tx_shift <= {tx_shift[spi_bridge_pkg::DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign mcu_sd_o = tx_shift[spi_bridge_pkg::DATA_WIDTH-1];  // MSB first

endmodule

`default_nettype wire

// File: target_ram.sv
// Target RAM, 2^17 bytes on the internal bus
// Acks a fixed number of cycles after stb
`timescale 1ns/10ps
`default_nettype none

module target_ram (
    input  logic spi_cs_ni,  // Design clock
    input  logic spi_sck_i,  // Async reset, active high
    wb_if.slave  bus
);

    spi_bridge_pkg::data_t    mem [spi_bridge_pkg::RAM_DEPTH];
    spi_bridge_pkg::lat_cnt_t lat_cnt;  // Cycles left until ack
    logic                     start;

    assign start = bus.cyc & bus.stb;

    // Array access happens at stb
    always_ff @(posedge spi_cs_ni) begin
        if (start) begin
            if (bus.we) begin
                mem[bus.adr] <= bus.dat_w;
            end else begin
                bus.dat_r <= mem[bus.adr];  // Held until ack
            end
        end
    end

    always_ff @(posedge spi_cs_ni or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            lat_cnt <= '0;
        end else if (start) begin
            lat_cnt <= spi_bridge_pkg::LAT_CNT_START;
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end
    end

    assign bus.ack = (lat_cnt == spi_bridge_pkg::LAT_CNT_LAST);  // One-cycle pulse

endmodule

`default_nettype wire

// File: tb_spi_bridge.sv
// Testbench for the SPI to memory bridge
// MCU-side SPI driver, memory and address model, six directed and random tests
`timescale 1ns/10ps
`default_nettype none

module tb_spi_bridge;

    localparam int SCK_HALF      = 4;                 // Design clocks per SCK half-period
    localparam int CLKS_PER_BYTE = 16 * SCK_HALF;
    localparam int MAX_FRAMES    = 300;
    localparam int MAX_BYTES     = 4;
    localparam int FRAME_CLKS    = MAX_BYTES * CLKS_PER_BYTE + 40;  // Bytes plus CS and bus time
    // Double the budget, rounded up to a whole 100000
    localparam int CYCLE_LIMIT   = ((2 * MAX_FRAMES * FRAME_CLKS) / 100000 + 1) * 100000;
    localparam int STALL_WAIT    = 4 * SCK_HALF;      // Last SCK fall to stall low, with margin

    logic spi_cs_ni;   // Design clock
    logic spi_sck_i;   // Reset
    logic mcu_cs_ni;
    logic mcu_sck_i;
    logic mcu_sd_i;
    logic mcu_sd_o;
    logic stall_o;

    integer seed = 34;
    int     cycles;
    int     checks;
    int     errors;
    int     test_errors;  // Error count when the current test began

    spi_bridge_pkg::data_t frame_q[$];                                  // Bytes of the next frame
    spi_bridge_pkg::data_t model_mem [0:spi_bridge_pkg::RAM_DEPTH-1];   // Unwritten bytes stay X
    spi_bridge_pkg::addr_t model_addr;
    spi_bridge_pkg::data_t model_last_read;                              // Next frame returns this

    spi_bridge_top DUT (
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .mcu_cs_ni (mcu_cs_ni),
        .mcu_sck_i (mcu_sck_i),
        .mcu_sd_i  (mcu_sd_i),
        .mcu_sd_o  (mcu_sd_o),
        .stall_o   (stall_o)
    );

    initial spi_cs_ni = 1'b0;
    always #10 spi_cs_ni = ~spi_cs_ni;  // 20 ns period

    // Run limit
    always @(posedge spi_cs_ni) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Simulation timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_byte(input spi_bridge_pkg::data_t got, input spi_bridge_pkg::data_t exp,
                              input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input spi_bridge_pkg::addr_t got, input spi_bridge_pkg::addr_t exp,
                              input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("[ERROR] %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Mode 0 frame from frame_q, MSB first, MISO sampled just before each rising SCK
    task automatic mcu_frame(input bit wait_stall, output spi_bridge_pkg::data_t first_rx,
                             output logic stall_mid, output logic stall_end);
        spi_bridge_pkg::data_t rx;
        int i;
        int b;
        int n;
        @(negedge spi_cs_ni);
        mcu_cs_ni = 1'b0;
        repeat (SCK_HALF) @(negedge spi_cs_ni);  // Lets the bridge load its tx byte
        for (i = 0; i < frame_q.size(); i++) begin
            for (b = spi_bridge_pkg::DATA_WIDTH - 1; b >= 0; b--) begin
                mcu_sd_i = frame_q[i][b];
                repeat (SCK_HALF) @(negedge spi_cs_ni);
                rx[b]     = mcu_sd_o;
                mcu_sck_i = 1'b1;
                repeat (SCK_HALF) @(negedge spi_cs_ni);
                mcu_sck_i = 1'b0;
            end
            if (i == 0) begin
                first_rx  = rx;
                stall_mid = stall_o;  // Command still open here
            end
        end
        mcu_sd_i = 1'b0;
        n = 0;
        while (wait_stall && stall_o && n < STALL_WAIT) begin
            @(negedge spi_cs_ni);
            n = n + 1;
        end
        stall_end = stall_o;  // Still high if the bus cycle did not finish in time
        mcu_cs_ni = 1'b1;
        repeat (2 * SCK_HALF) @(negedge spi_cs_ni);  // CS high gap
    endtask

    // One complete command, checked against the model
    task automatic run_cmd(input logic we, input logic set_addr, input spi_bridge_pkg::addr_t addr,
                           input spi_bridge_pkg::data_t data, input int n_extra,
                           input string what);
        spi_bridge_pkg::data_t cmd_byte;
        spi_bridge_pkg::data_t exp_rx;
        spi_bridge_pkg::data_t rx_first;
        logic stall_mid;
        logic stall_end;
        int i;
        exp_rx   = model_last_read;
        cmd_byte = spi_bridge_pkg::data_t'($random(seed));  // Don't-care bits random
        cmd_byte[spi_bridge_pkg::CMD_WRITE_BIT]   = we;
        cmd_byte[spi_bridge_pkg::CMD_SETADDR_BIT] = set_addr;
        if (set_addr) begin
            cmd_byte[spi_bridge_pkg::CMD_A16_BIT] = addr[spi_bridge_pkg::ADDR_WIDTH-1];
        end
        frame_q.delete();
        frame_q.push_back(cmd_byte);
        if (we) begin
            frame_q.push_back(data);
        end
        if (set_addr) begin
            frame_q.push_back(addr[15:8]);
            frame_q.push_back(addr[7:0]);
        end
        for (i = 0; i < n_extra; i++) begin
            frame_q.push_back(spi_bridge_pkg::data_t'($random(seed)));  // Ignored by the bridge
        end
        mcu_frame(1'b1, rx_first, stall_mid, stall_end);
        check_byte(rx_first, exp_rx, {what, ": returned byte"});
        check_level(stall_mid, 1'b1, {what, ": stall while command open"});
        check_level(stall_end, 1'b0, {what, ": stall before frame end"});
        // Model update
        if (set_addr) begin
            model_addr = addr;
        end else begin
            model_addr = spi_bridge_pkg::addr_t'(model_addr + 1'b1);  // Wraps at 2^17
        end
        if (we) begin
            model_mem[model_addr] = data;
        end else begin
            model_last_read = model_mem[model_addr];
        end
        check_addr(DUT.cmd_bus.addr, model_addr, {what, ": address register"});
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: FAILED with %0d mismatches", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        spi_bridge_pkg::data_t fill [4];
        spi_bridge_pkg::data_t rx_first;
        spi_bridge_pkg::addr_t addr;
        logic stall_mid;
        logic stall_end;
        int i;
        int r;
        int n;

        spi_sck_i       = 1'b1;
        mcu_cs_ni       = 1'b1;
        mcu_sck_i       = 1'b0;
        mcu_sd_i        = 1'b0;
        cycles          = 0;
        checks          = 0;
        errors          = 0;
        test_errors     = 0;
        model_addr      = '0;
        model_last_read = '0;
        repeat (10) @(negedge spi_cs_ni);
        spi_sck_i = 1'b0;
        repeat (4) @(negedge spi_cs_ni);

        // 1: reset values, first returned byte is zero
        check_level(stall_o, 1'b0, "stall after reset");
        check_level(mcu_sd_o, 1'b0, "MISO after reset");
        check_addr(DUT.cmd_bus.addr, '0, "address after reset");
        run_cmd(1'b1, 1'b1, 17'h00A5C, 8'h3C, 0, "first frame");
        report_test(1, "reset state");

        // 2: set-address write and readback, A16 low and high
        run_cmd(1'b1, 1'b1, 17'h01234, spi_bridge_pkg::data_t'($random(seed)), 0, "write A16=0");
        run_cmd(1'b1, 1'b1, 17'h11234, spi_bridge_pkg::data_t'($random(seed)), 0, "write A16=1");
        run_cmd(1'b0, 1'b1, 17'h01234, 8'h00, 0, "read A16=0");
        run_cmd(1'b0, 1'b1, 17'h11234, 8'h00, 0, "read A16=1");
        run_cmd(1'b0, 1'b1, 17'h01234, 8'h00, 0, "reread A16=0");
        report_test(2, "set-address write and read");

        // 3: increment mode across the top of the address space
        for (i = 0; i < 4; i++) begin
            fill[i] = spi_bridge_pkg::data_t'($random(seed));
        end
        run_cmd(1'b1, 1'b1, 17'h1FFFE, fill[0], 0, "fill base");
        for (i = 1; i < 4; i++) begin
            run_cmd(1'b1, 1'b0, '0, fill[i], 0, "fill increment");
        end
        run_cmd(1'b0, 1'b1, 17'h1FFFE, 8'h00, 0, "read base");
        for (i = 1; i < 4; i++) begin
            run_cmd(1'b0, 1'b0, '0, 8'h00, 0, "read increment");
        end
        report_test(3, "increment and wrap");

        // 4: stall over a complete and a cut-short frame
        run_cmd(1'b1, 1'b1, 17'h00100, spi_bridge_pkg::data_t'($random(seed)), 0,
                "complete write");
        frame_q.delete();
        frame_q.push_back(8'hC0);  // Write with set-address, data and address never sent
        mcu_frame(1'b0, rx_first, stall_mid, stall_end);
        check_byte(rx_first, model_last_read, "short frame: returned byte");
        check_level(stall_mid, 1'b1, "short frame: stall while command open");
        n = 0;
        while (stall_o && n < 20) begin
            @(negedge spi_cs_ni);
            n = n + 1;
        end
        check_level(stall_o, 1'b0, "stall after short frame");
        run_cmd(1'b0, 1'b1, 17'h00100, 8'h00, 0, "read after short frame");
        report_test(4, "stall");

        // 5: trailing bytes after a complete command
        run_cmd(1'b1, 1'b1, 17'h10200, spi_bridge_pkg::data_t'($random(seed)), 2,
                "write with extra bytes");
        run_cmd(1'b0, 1'b1, 17'h10200, 8'h00, 3, "read with extra bytes");
        run_cmd(1'b1, 1'b0, '0, spi_bridge_pkg::data_t'($random(seed)), 2,
                "increment write with extra bytes");
        run_cmd(1'b0, 1'b0, '0, 8'h00, 1, "increment read with extra byte");
        run_cmd(1'b0, 1'b1, 17'h10200, 8'h00, 0, "readback");
        report_test(5, "extra bytes");

        // 6: random frames in a small window near the top of each half
        for (i = 0; i < 250; i++) begin
            r    = $random(seed);
            addr = spi_bridge_pkg::addr_t'($random(seed));
            addr[15:6] = 10'h3FF;
            run_cmd(r[0], r[1], addr, spi_bridge_pkg::data_t'($random(seed)), 0, "random frame");
        end
        run_cmd(1'b0, 1'b0, '0, 8'h00, 0, "last random readback");
        report_test(6, "random frames");

        $display("Checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_if.sv
// Internal single-master Wishbone-style bus
// stb pulses once per cycle, cyc holds until ack
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

    logic                  cyc;    // Cycle in progress
    logic                  stb;    // Request strobe, one cycle
    logic                  we;     // 1 = write
    spi_bridge_pkg::addr_t adr;
    spi_bridge_pkg::data_t dat_w;  // Master to slave
    logic                  ack;    // One-cycle termination pulse
    spi_bridge_pkg::data_t dat_r;  // Valid with ack

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  ack,
        input  dat_r
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output ack,
        output dat_r
    );

endinterface

`default_nettype wire
